// ==== flist.f ====
hdl/tcn_pkg.sv
hdl/dilated_tap_line.sv
hdl/dilated_conv.sv
hdl/layer_sequencer.sv
hdl/tcn_top.sv
bench/tcn_properties.sv
bench/tcn_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tcn_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tcn_tb.sv ====
`timescale 1ns/10ps

module tcn_tb;
    import tcn_pkg::*;

    localparam int  NUM_ENTRIES = 68;
    localparam int  L0_DEPTH    = (TAPS - 1) * L1_DILATION + 1;
    localparam int  WAIT_LIMIT  = 60;
    localparam time DRIVE_DLY   = 2;

    typedef struct {
        sample_t sample;
        bit      inject;
        int      group;
    } stim_entry_t;

    logic    clk;
    logic    rst;
    logic    sample_valid;
    sample_t sample_in;
    sample_t sample_out0;
    sample_t sample_out1;
    sample_t sample_out2;
    sample_t sample_out3;
    logic    out_valid;
    logic    busy;

    stim_entry_t stim [NUM_ENTRIES];
    string       group_name [5] = '{"impulse", "mixed", "full_scale", "dropped", "random"};
    int          fill_idx;

    // golden model state
    sample_t m_in [TAPS];
    sample_t m_l0 [CHANNELS][L0_DEPTH];
    sample_t m_out [CHANNELS];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int valid_count = 0;
    bit timed_out;

    tcn_top u_tcn_top (
        .clk(clk), .rst(rst), .sample_valid(sample_valid), .sample_in(sample_in),
        .sample_out0(sample_out0), .sample_out1(sample_out1),
        .sample_out2(sample_out2), .sample_out3(sample_out3),
        .out_valid(out_valid), .busy(busy)
    );

    always #20 clk = ~clk;

    // pulses are counted on the edge that ends them
    always @(posedge clk) begin
        if (out_valid === 1'b1) begin
            valid_count++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // --------------------
    // golden model

    function automatic sample_t rescale_clamp(input acc_t a, input bit relu);
        acc_t s;
        s = a >>> FRAC_BITS;
        if (relu && s < 0) begin
            s = '0;
        end
        if (s > acc_t'(32767)) begin
            return sample_t'(16'h7fff);
        end
        if (s < acc_t'(-32768)) begin
            return sample_t'(16'h8000);
        end
        return sample_t'(s);
    endfunction

    task automatic model_step(input sample_t s);
        acc_t    acc;
        sample_t l0 [CHANNELS];
        for (int k = TAPS - 1; k > 0; k--) begin
            m_in[k] = m_in[k-1];
        end
        m_in[0] = s;
        for (int o = 0; o < CHANNELS; o++) begin
            acc = acc_t'(layer_bias(0, o)) <<< FRAC_BITS;
            for (int k = 0; k < TAPS; k++) begin
                acc = acc + acc_t'(m_in[k]) * acc_t'(layer_weight(0, o, 0, k));
            end
            l0[o] = rescale_clamp(acc, NUM_LAYERS - 1 != 0);
        end
        for (int c = 0; c < CHANNELS; c++) begin
            for (int i = L0_DEPTH - 1; i > 0; i--) begin
                m_l0[c][i] = m_l0[c][i-1];
            end
            m_l0[c][0] = l0[c];
        end
        // layer 1 reaches back L1_DILATION samples per tap
        for (int o = 0; o < CHANNELS; o++) begin
            acc = acc_t'(layer_bias(1, o)) <<< FRAC_BITS;
            for (int c = 0; c < CHANNELS; c++) begin
                for (int k = 0; k < TAPS; k++) begin
                    acc = acc + acc_t'(m_l0[c][k*L1_DILATION])
                        * acc_t'(layer_weight(1, o, c, k));
                end
            end
            m_out[o] = rescale_clamp(acc, NUM_LAYERS - 1 != 1);
        end
    endtask

    // --------------------
    // checks and waits

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_out_valid(output bit ok);
        int cycles;
        cycles = 0;
        while (out_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        ok = (out_valid === 1'b1);
    endtask

    task automatic add_entry(input sample_t s, input bit inject, input int group);
        stim[fill_idx] = '{sample: s, inject: inject, group: group};
        fill_idx++;
    endtask

    task automatic fill_table();
        sample_t     mixed [8] = '{-300, -50, 120, -700, 400, -20, 0, 90};
        logic [31:0] rng;
        fill_idx = 0;
        add_entry(256, 0, 0);
        for (int i = 0; i < 15; i++) begin
            add_entry(0, 0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_entry(mixed[i], 0, 1);
        end
        for (int i = 0; i < 10; i++) begin
            add_entry((i >= 4 && i < 8) ? sample_t'(16'h8000) : sample_t'(16'h7fff), 0, 2);
        end
        add_entry(200, 1, 3);
        add_entry(-150, 1, 3);
        add_entry(75, 0, 3);
        add_entry(500, 1, 3);
        rng = 32'd56267;
        for (int i = 0; i < 30; i++) begin
            rng = xorshift32(rng);
            add_entry(sample_t'($signed(rng[15:0]) >>> 3), 0, 4);
        end
    endtask

    task automatic apply_entry(input int idx, output bit ok);
        int count_before;
        count_before = valid_count;
        sample_in    = stim[idx].sample;
        sample_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        sample_valid = 1'b0;
        model_step(stim[idx].sample);
        check_flag("busy", busy, 1'b1);
        if (stim[idx].inject) begin
            // DUT drops this one and the model never sees it
            sample_in    = ~stim[idx].sample;
            sample_valid = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            sample_valid = 1'b0;
        end
        wait_out_valid(ok);
        if (!ok) begin
            $display("timeout: no out_valid within %0d cycles for entry %0d", WAIT_LIMIT, idx);
            return;
        end
        check_sample("sample_out0", sample_out0, m_out[0]);
        check_sample("sample_out1", sample_out1, m_out[1]);
        check_sample("sample_out2", sample_out2, m_out[2]);
        check_sample("sample_out3", sample_out3, m_out[3]);
        @(posedge clk);
        #DRIVE_DLY;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        if (valid_count - count_before != 1) begin
            $display("entry %0d gave %0d out_valid pulses instead of one",
                idx, valid_count - count_before);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-10s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
            test_errors);
    endtask

    // --------------------
    // main sequence

    initial begin
        bit ok;
        clk          = 1'b0;
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample_in    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        fill_table();
        for (int k = 0; k < TAPS; k++) begin
            m_in[k] = '0;
        end
        for (int c = 0; c < CHANNELS; c++) begin
            for (int i = 0; i < L0_DEPTH; i++) begin
                m_l0[c][i] = '0;
            end
        end
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        test_errors = 0;
        check_flag("busy", busy, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        check_sample("sample_out0", sample_out0, '0);
        check_sample("sample_out1", sample_out1, '0);
        check_sample("sample_out2", sample_out2, '0);
        check_sample("sample_out3", sample_out3, '0);
        report_test("reset");

        for (int i = 0; i < NUM_ENTRIES && !timed_out; i++) begin
            if (i == 0 || stim[i].group != stim[i-1].group) begin
                test_errors = 0;
            end
            apply_entry(i, ok);
            if (!ok) begin
                timed_out = 1'b1;
                test_errors++;
            end
            if (!ok || i == NUM_ENTRIES - 1 || stim[i+1].group != stim[i].group) begin
                report_test(group_name[stim[i].group]);
            end
        end

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
            tests_run, tests_failed, errors, u_tcn_top.u_tcn_properties.failures);
        if (errors == 0 && !timed_out && u_tcn_top.u_tcn_properties.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/tcn_properties.sv ====
`timescale 1ns/10ps

module tcn_properties (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic busy,
    input logic start1
);
    int busy_cycles;
    int failures = 0;

    // length of the current busy stretch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_cycles <= 0;
        end else if (busy) begin
            busy_cycles <= busy_cycles + 1;
        end else begin
            busy_cycles <= 0;
        end
    end

    a_out_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid stayed high for more than one cycle");
            failures++;
        end

    a_busy_bounded: assert property (@(posedge clk) disable iff (rst)
        busy_cycles <= 40)
        else begin
            $error("busy stayed high for more than 40 cycles");
            failures++;
        end

    a_start1_busy: assert property (@(posedge clk) disable iff (rst)
        start1 |-> busy)
        else begin
            $error("start1 high while busy is low");
            failures++;
        end

endmodule

bind tcn_top tcn_properties u_tcn_properties (
    .clk(clk), .rst(rst), .out_valid(out_valid), .busy(busy), .start1(start1)
);

// ==== hdl/tcn_top.sv ====
`timescale 1ns/10ps

module tcn_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    input  tcn_pkg::sample_t sample_in,
    output tcn_pkg::sample_t sample_out0,
    output tcn_pkg::sample_t sample_out1,
    output tcn_pkg::sample_t sample_out2,
    output tcn_pkg::sample_t sample_out3,
    output logic             out_valid,
    output logic             busy
);
    import tcn_pkg::*;

    logic    in_shift;
    logic    start0;
    logic    start1;
    logic    cache_shift;
    logic    done0;
    logic    done1;
    sample_t in_din [1];
    sample_t in_taps [1][TAPS];
    sample_t l0_result [CHANNELS];
    sample_t l0_taps [CHANNELS][TAPS];
    sample_t l1_result [CHANNELS];
    sample_t sample_out [CHANNELS];

    assign in_din[0] = sample_in;

    // --------------------
    // layer 0 with dilation 1 over the raw samples

    dilated_tap_line #(.CHANNELS_IN(1), .DILATION(1)) u_in_line (
        .clk(clk), .rst(rst), .shift(in_shift), .din(in_din), .taps(in_taps)
    );

    dilated_conv #(.LAYER(0), .IN_CHANNELS(1)) u_conv0 (
        .clk(clk), .rst(rst), .start(start0), .taps(in_taps),
        .done(done0), .result(l0_result)
    );

    // --------------------
    // layer 1 over the cached layer 0 activations

    dilated_tap_line #(.CHANNELS_IN(CHANNELS), .DILATION(L1_DILATION)) u_l0_cache (
        .clk(clk), .rst(rst), .shift(cache_shift), .din(l0_result), .taps(l0_taps)
    );

    dilated_conv #(.LAYER(1), .IN_CHANNELS(CHANNELS)) u_conv1 (
        .clk(clk), .rst(rst), .start(start1), .taps(l0_taps),
        .done(done1), .result(l1_result)
    );

    layer_sequencer u_seq (
        .clk(clk), .rst(rst), .sample_valid(sample_valid),
        .done0(done0), .done1(done1), .l1_result(l1_result),
        .in_shift(in_shift), .start0(start0), .start1(start1),
        .cache_shift(cache_shift), .out_valid(out_valid), .busy(busy),
        .sample_out(sample_out)
    );

    assign sample_out0 = sample_out[0];
    assign sample_out1 = sample_out[1];
    assign sample_out2 = sample_out[2];
    assign sample_out3 = sample_out[3];

endmodule

// ==== hdl/layer_sequencer.sv ====
`timescale 1ns/10ps

module layer_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample_valid,
    input  logic             done0,
    input  logic             done1,
    input  tcn_pkg::sample_t l1_result [tcn_pkg::CHANNELS],
    output logic             in_shift,
    output logic             start0,
    output logic             start1,
    output logic             cache_shift,
    output logic             out_valid,
    output logic             busy,
    output tcn_pkg::sample_t sample_out [tcn_pkg::CHANNELS]
);
    import tcn_pkg::*;

    seq_state_t state;

    // samples are only taken while idle and the rest are dropped
    assign in_shift    = sample_valid && (state == SEQ_IDLE);
    assign cache_shift = done0 && (state == SEQ_RUN0);
    assign busy        = (state != SEQ_IDLE);

    // --------------------
    // layer sequencing

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SEQ_IDLE;
            start0    <= 1'b0;
            start1    <= 1'b0;
            out_valid <= 1'b0;
            for (int c = 0; c < CHANNELS; c++) begin
                sample_out[c] <= '0;
            end
        end else begin
            start0    <= 1'b0;
            start1    <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (in_shift) begin
                        state  <= SEQ_RUN0;
                        start0 <= 1'b1;
                    end
                end
                SEQ_RUN0: begin
                    // cache takes the layer 0 result on this edge
                    if (done0) begin
                        state  <= SEQ_RUN1;
                        start1 <= 1'b1;
                    end
                end
                SEQ_RUN1: begin
                    if (done1) begin
                        state     <= SEQ_IDLE;
                        out_valid <= 1'b1;
                        for (int c = 0; c < CHANNELS; c++) begin
                            sample_out[c] <= l1_result[c];
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/dilated_conv.sv ====
`timescale 1ns/10ps

module dilated_conv #(
    parameter int LAYER       = 0,
    parameter int IN_CHANNELS = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  tcn_pkg::sample_t taps [IN_CHANNELS][tcn_pkg::TAPS],
    output logic             done,
    output tcn_pkg::sample_t result [tcn_pkg::CHANNELS]
);
    import tcn_pkg::*;

    localparam int   TERMS      = IN_CHANNELS * TAPS;
    localparam int   CNT_W      = $clog2(TERMS);
    localparam bit   APPLY_RELU = (LAYER != NUM_LAYERS - 1);
    localparam acc_t SAT_HI     = (acc_t'(1) <<< (SAMPLE_W - 1)) - acc_t'(1);
    localparam acc_t SAT_LO     = -(acc_t'(1) <<< (SAMPLE_W - 1));

    logic             running;
    logic [CNT_W-1:0] term;
    logic             last_term;
    int               in_ch;
    int               tap;
    acc_t             acc [CHANNELS];
    acc_t             acc_next [CHANNELS];

    // rescale with optional relu and a clamp to the sample range
    function automatic sample_t finish(input acc_t a);
        acc_t s;
        s = a >>> FRAC_BITS;
        if (APPLY_RELU && s < 0) begin
            s = '0;
        end
        if (s > SAT_HI) begin
            s = SAT_HI;
        end else if (s < SAT_LO) begin
            s = SAT_LO;
        end
        return sample_t'(s);
    endfunction

    // --------------------
    // term decode and one product per output channel

    assign in_ch     = int'(term) / TAPS;
    assign tap       = int'(term) % TAPS;
    assign last_term = (term == CNT_W'(TERMS - 1));

    always_comb begin
        for (int o = 0; o < CHANNELS; o++) begin
            acc_next[o] = acc[o]
                + acc_t'(taps[in_ch][tap]) * acc_t'(layer_weight(LAYER, o, in_ch, tap));
        end
    end

    // --------------------
    // control

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            term    <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                term    <= '0;
            end else if (running) begin
                term <= term + 1'b1;
                if (last_term) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // accumulators and results
    always_ff @(posedge clk) begin
        for (int o = 0; o < CHANNELS; o++) begin
            if (start) begin
                acc[o] <= acc_t'(layer_bias(LAYER, o)) <<< FRAC_BITS;
            end else if (running) begin
                acc[o] <= acc_next[o];
                // last product folds straight into the result
                if (last_term) begin
                    result[o] <= finish(acc_next[o]);
                end
            end
        end
    end

endmodule

// ==== hdl/dilated_tap_line.sv ====
`timescale 1ns/10ps

module dilated_tap_line #(
    parameter int CHANNELS_IN = 1,
    parameter int DILATION    = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             shift,
    input  tcn_pkg::sample_t din [CHANNELS_IN],
    output tcn_pkg::sample_t taps [CHANNELS_IN][tcn_pkg::TAPS]
);
    import tcn_pkg::*;

    // oldest tap sits (TAPS-1)*DILATION shifts back
    localparam int DEPTH = (TAPS - 1) * DILATION + 1;

    sample_t hist [CHANNELS_IN][DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < CHANNELS_IN; c++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    hist[c][i] <= '0;
                end
            end
        end else if (shift) begin
            for (int c = 0; c < CHANNELS_IN; c++) begin
                hist[c][0] <= din[c];
                for (int i = 1; i < DEPTH; i++) begin
                    hist[c][i] <= hist[c][i-1];
                end
            end
        end
    end

    // fixed tap positions into the history
    for (genvar c = 0; c < CHANNELS_IN; c++) begin : g_chan
        for (genvar k = 0; k < TAPS; k++) begin : g_tap
            assign taps[c][k] = hist[c][k*DILATION];
        end
    end

endmodule

// ==== hdl/tcn_pkg.sv ====
package tcn_pkg;

    localparam int SAMPLE_W    = 16;
    localparam int FRAC_BITS   = 8;
    localparam int ACC_W       = 40;
    localparam int CHANNELS    = 4;
    localparam int TAPS        = 4;
    localparam int L1_DILATION = 4;
    localparam int NUM_LAYERS  = 2;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [SAMPLE_W-1:0] weight_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN0,
        SEQ_RUN1
    } seq_state_t;

    // --------------------
    // Q8.8 coefficients as [out][tap] for layer 0 and [out][in][tap] for layer 1

    localparam weight_t L0_WEIGHTS [CHANNELS][TAPS] = '{
        '{ 192,  128,   64,  -32},
        '{ -96,  160,  -48,   80},
        '{  64, -128,   96,   32},
        '{ 112,   48,  -80,  144}
    };

    localparam weight_t L0_BIAS [CHANNELS] = '{16, -8, 24, 0};

    localparam weight_t L1_WEIGHTS [CHANNELS][CHANNELS][TAPS] = '{
        '{'{ 96, -32,  48,  16}, '{-64,  80,  24, -40},
          '{ 32,  56, -72,  88}, '{ 40, -24, 112,  -8}},
        '{'{-48,  72, -16,  64}, '{120, -96,  40,  20},
          '{ -8,  36,  60, -52}, '{ 76,  12, -44,  28}},
        '{'{ 24,  -8,  88, -60}, '{ 16,  44, -20, 100},
          '{-84,  68,  52,  12}, '{ 36, -56,  20,  92}},
        '{'{ 60,  84, -36,  44}, '{-28,  16,  72, -12},
          '{104, -40,   8,  56}, '{-20,  64, -88,  48}}
    };

    localparam weight_t L1_BIAS [CHANNELS] = '{-12, 20, 4, -28};

    // --------------------
    // layer 0 has a single input channel so in_ch is ignored there

    function automatic weight_t layer_weight(
        input int layer,
        input int out_ch,
        input int in_ch,
        input int tap
    );
        if (layer == 0) begin
            return L0_WEIGHTS[out_ch][tap];
        end
        return L1_WEIGHTS[out_ch][in_ch][tap];
    endfunction

    function automatic weight_t layer_bias(input int layer, input int out_ch);
        if (layer == 0) begin
            return L0_BIAS[out_ch];
        end
        return L1_BIAS[out_ch];
    endfunction

endpackage
